//--- list.f
source/rvPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/pipeCpu.sv
tb/pipeCpu_chk.sv
tb/pipeCpuTb.sv

//--- run.sh
#!/bin/sh
# builds the pipeline testbench with Verilator, runs it, and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module pipeCpuTb -f list.f -o simPipeCpu \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simPipeCpu > sim.log 2>&1
grep -q "Test FAILED" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Test OK" sim.log || { echo "FAIL, no result in sim.log"; exit 1; }
echo "PASS"

//--- source/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage #(
    parameter int xlen = 32
)(
    input  logic clk,
    input  logic rstN,
    input  logic flushE,
    input  logic [xlen-1:0] instrD,
    input  logic [xlen-1:0] pcD,
    input  logic [xlen-1:0] pcPlus4D,
    input  logic regWriteW,
    input  logic [rvPkg::regAddrBits-1:0] rdW,
    input  logic [xlen-1:0] resultW,
    output logic regWriteE,
    output logic [1:0] resultSrcE,
    output logic memWriteE,
    output logic branchE,
    output logic branchNeE,
    output logic jumpE,
    output logic [2:0] aluOpE,
    output logic aluSrcE,
    output logic [xlen-1:0] rd1E,
    output logic [xlen-1:0] rd2E,
    output logic [xlen-1:0] pcE,
    output logic [xlen-1:0] immE,
    output logic [xlen-1:0] pcPlus4E,
    output logic [rvPkg::regAddrBits-1:0] rs1E,
    output logic [rvPkg::regAddrBits-1:0] rs2E,
    output logic [rvPkg::regAddrBits-1:0] rdE,
    output logic [rvPkg::regAddrBits-1:0] rs1D,
    output logic [rvPkg::regAddrBits-1:0] rs2D,
    output logic [xlen-1:0] a0
);

    logic [xlen-1:0] regs [32];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic funct7b5;
    logic regWriteD, memWriteD, branchD, jumpD, aluSrcD, usesRs1, usesRs2;
    logic [1:0] resultSrcD;
    logic [2:0] aluOpD;
    logic [xlen-1:0] immD, rd1D, rd2D;
    logic [rvPkg::regAddrBits-1:0] rdD;

    assign opcode   = instrD[6:0];
    assign funct3   = instrD[14:12];
    assign funct7b5 = instrD[30];
    assign rdD      = instrD[11:7];

    always_comb begin
        regWriteD  = 1'b0;
        resultSrcD = rvPkg::resAlu;
        memWriteD  = 1'b0;
        branchD    = 1'b0;
        jumpD      = 1'b0;
        aluSrcD    = 1'b0;
        aluOpD     = rvPkg::aluAdd;
        immD       = '0;
        usesRs1    = 1'b0;
        usesRs2    = 1'b0;
        case (opcode)
            rvPkg::opReg, rvPkg::opImm: begin
                regWriteD = 1'b1;
                usesRs1   = 1'b1;
                usesRs2   = (opcode == rvPkg::opReg);
                aluSrcD   = (opcode == rvPkg::opImm);
                immD      = {{(xlen-12){instrD[31]}}, instrD[31:20]};
                case (funct3)
                    3'b111: aluOpD = rvPkg::aluAnd;
                    3'b110: aluOpD = rvPkg::aluOr;
                    3'b010: aluOpD = rvPkg::aluSlt;
                    // sub only for register form with funct7 bit 5
                    default: aluOpD = (usesRs2 && funct7b5) ? rvPkg::aluSub : rvPkg::aluAdd;
                endcase
            end
            rvPkg::opLoad: begin
                regWriteD  = 1'b1;
                resultSrcD = rvPkg::resMem;
                aluSrcD    = 1'b1;
                usesRs1    = 1'b1;
                immD       = {{(xlen-12){instrD[31]}}, instrD[31:20]};
            end
            rvPkg::opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                usesRs1   = 1'b1;
                usesRs2   = 1'b1;
                immD      = {{(xlen-12){instrD[31]}}, instrD[31:25], instrD[11:7]};
            end
            rvPkg::opBranch: begin
                branchD = 1'b1;
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                immD    = {{(xlen-12){instrD[31]}}, instrD[7], instrD[30:25],
                           instrD[11:8], 1'b0};
            end
            rvPkg::opJal: begin
                regWriteD  = 1'b1;
                resultSrcD = rvPkg::resPc4;
                jumpD      = 1'b1;
                immD       = {{(xlen-20){instrD[31]}}, instrD[19:12], instrD[20],
                              instrD[30:21], 1'b0};
            end
            rvPkg::opLui: begin
                // rs1 forced to x0 so the alu adds zero to the immediate
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immD      = {{(xlen-31){instrD[31]}}, instrD[30:12], 12'b0};
            end
            default: ;
        endcase
    end

    // unused source fields read x0, avoids false stalls and forwards
    assign rs1D = usesRs1 ? instrD[19:15] : '0;
    assign rs2D = usesRs2 ? instrD[24:20] : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWriteW && rdW != '0) begin
            regs[rdW] <= resultW;
        end
    end

    // write-through from writeback
    assign rd1D = (regWriteW && rdW != '0 && rdW == rs1D) ? resultW : regs[rs1D];
    assign rd2D = (regWriteW && rdW != '0 && rdW == rs2D) ? resultW : regs[rs2D];
    assign a0   = regs[10];

    always_ff @(posedge clk) begin
        if (!rstN || flushE) begin
            regWriteE  <= 1'b0;
            resultSrcE <= rvPkg::resAlu;
            memWriteE  <= 1'b0;
            branchE    <= 1'b0;
            branchNeE  <= 1'b0;
            jumpE      <= 1'b0;
            aluOpE     <= rvPkg::aluAdd;
            aluSrcE    <= 1'b0;
            rs1E       <= '0;
            rs2E       <= '0;
            rdE        <= '0;
        end else begin
            regWriteE  <= regWriteD;
            resultSrcE <= resultSrcD;
            memWriteE  <= memWriteD;
            branchE    <= branchD;
            branchNeE  <= branchD & funct3[0];
            jumpE      <= jumpD;
            aluOpE     <= aluOpD;
            aluSrcE    <= aluSrcD;
            rs1E       <= rs1D;
            rs2E       <= rs2D;
            rdE        <= rdD;
        end
    end

    always_ff @(posedge clk) begin
        rd1E     <= rd1D;
        rd2E     <= rd2D;
        pcE      <= pcD;
        immE     <= immD;
        pcPlus4E <= pcPlus4D;
    end

endmodule

`default_nettype wire

//--- source/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage #(
    parameter int xlen = 32
)(
    input  logic clk,
    input  logic rstN,
    input  logic regWriteE,
    input  logic [1:0] resultSrcE,
    input  logic memWriteE,
    input  logic branchE,
    input  logic branchNeE,
    input  logic jumpE,
    input  logic [2:0] aluOpE,
    input  logic aluSrcE,
    input  logic [xlen-1:0] rd1E,
    input  logic [xlen-1:0] rd2E,
    input  logic [xlen-1:0] pcE,
    input  logic [xlen-1:0] immE,
    input  logic [xlen-1:0] pcPlus4E,
    input  logic [rvPkg::regAddrBits-1:0] rdE,
    input  logic [1:0] forwardAE,
    input  logic [1:0] forwardBE,
    input  logic [xlen-1:0] resultW,
    output logic pcSrcE,
    output logic [xlen-1:0] pcTargetE,
    output logic regWriteM,
    output logic [1:0] resultSrcM,
    output logic memWriteM,
    output logic [xlen-1:0] aluResultM,
    output logic [xlen-1:0] writeDataM,
    output logic [rvPkg::regAddrBits-1:0] rdM,
    output logic [xlen-1:0] pcPlus4M
);

    logic [xlen-1:0] srcAE, srcBE, writeDataE, aluResultE;
    logic equalE;

    function automatic logic [xlen-1:0] pickOperand(
        input logic [1:0] sel,
        input logic [xlen-1:0] regVal,
        input logic [xlen-1:0] wbVal,
        input logic [xlen-1:0] memVal
    );
        case (sel)
            rvPkg::fwdMem: return memVal;
            rvPkg::fwdWb:  return wbVal;
            default:       return regVal;
        endcase
    endfunction

    assign srcAE      = pickOperand(forwardAE, rd1E, resultW, aluResultM);
    assign writeDataE = pickOperand(forwardBE, rd2E, resultW, aluResultM);
    assign srcBE      = aluSrcE ? immE : writeDataE;

    always_comb begin
        case (aluOpE)
            rvPkg::aluSub: aluResultE = srcAE - srcBE;
            rvPkg::aluAnd: aluResultE = srcAE & srcBE;
            rvPkg::aluOr:  aluResultE = srcAE | srcBE;
            rvPkg::aluSlt: aluResultE = {{(xlen-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
            default:       aluResultE = srcAE + srcBE;
        endcase
    end

    // beq/bne on operand equality, bne inverts
    assign equalE    = (srcAE == writeDataE);
    assign pcSrcE    = (branchE & (equalE ^ branchNeE)) | jumpE;
    assign pcTargetE = pcE + immE;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteM  <= 1'b0;
            resultSrcM <= rvPkg::resAlu;
            memWriteM  <= 1'b0;
            rdM        <= '0;
        end else begin
            regWriteM  <= regWriteE;
            resultSrcM <= resultSrcE;
            memWriteM  <= memWriteE;
            rdM        <= rdE;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
    end

endmodule

`default_nettype wire

//--- source/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage #(
    parameter int xlen = 32,
    parameter int imemAddrBits = 6
)(
    input  logic clk,
    input  logic rstN,
    input  logic run,
    input  logic loadEn,
    input  logic [imemAddrBits-1:0] loadAddr,
    input  logic [xlen-1:0] loadData,
    input  logic stallF,
    input  logic stallD,
    input  logic flushD,
    input  logic pcSrcE,
    input  logic [xlen-1:0] pcTargetE,
    output logic [xlen-1:0] instrD,
    output logic [xlen-1:0] pcD,
    output logic [xlen-1:0] pcPlus4D
);

    logic [xlen-1:0] imem [2**imemAddrBits];
    logic [xlen-1:0] pcF, pcPlus4F, pcNextF, instrF;

    assign pcPlus4F = pcF + xlen'(4);
    assign pcNextF  = pcSrcE ? pcTargetE : pcPlus4F;
    // word addressed, low two pc bits dropped
    assign instrF   = imem[pcF[imemAddrBits+1:2]];

    // program load only while stopped
    always_ff @(posedge clk) begin
        if (loadEn && !run) begin
            imem[loadAddr] <= loadData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || !run) begin
            pcF <= '0;
        end else if (!stallF) begin
            pcF <= pcNextF;
        end
    end

    // zero word is a bubble, decodes to no-op
    always_ff @(posedge clk) begin
        if (!rstN || !run || flushD) begin
            instrD   <= '0;
            pcD      <= '0;
            pcPlus4D <= '0;
        end else if (!stallD) begin
            instrD   <= instrF;
            pcD      <= pcF;
            pcPlus4D <= pcPlus4F;
        end
    end

endmodule

`default_nettype wire

//--- source/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
    input  logic [rvPkg::regAddrBits-1:0] rs1D,
    input  logic [rvPkg::regAddrBits-1:0] rs2D,
    input  logic [rvPkg::regAddrBits-1:0] rs1E,
    input  logic [rvPkg::regAddrBits-1:0] rs2E,
    input  logic [rvPkg::regAddrBits-1:0] rdE,
    input  logic [1:0] resultSrcE,
    input  logic pcSrcE,
    input  logic [rvPkg::regAddrBits-1:0] rdM,
    input  logic regWriteM,
    input  logic [rvPkg::regAddrBits-1:0] rdW,
    input  logic regWriteW,
    output logic [1:0] forwardAE,
    output logic [1:0] forwardBE,
    output logic stallF,
    output logic stallD,
    output logic flushD,
    output logic flushE
);

    logic lwStall;

    // memory stage is newer, so it wins over writeback
    function automatic logic [1:0] forwardFor(input logic [rvPkg::regAddrBits-1:0] rs);
        if (rs != '0 && regWriteM && rs == rdM) begin
            return rvPkg::fwdMem;
        end else if (rs != '0 && regWriteW && rs == rdW) begin
            return rvPkg::fwdWb;
        end
        return rvPkg::fwdReg;
    endfunction

    always_comb begin
        forwardAE = forwardFor(rs1E);
        forwardBE = forwardFor(rs2E);
    end

    // load in execute feeding the instruction in decode
    assign lwStall = (resultSrcE == rvPkg::resMem) && (rdE != '0)
                     && (rdE == rs1D || rdE == rs2D);

    assign stallF = lwStall;
    assign stallD = lwStall;
    assign flushD = pcSrcE;
    assign flushE = lwStall | pcSrcE;

endmodule

`default_nettype wire

//--- source/memoryStage.sv
`timescale 1ns/1ns
`default_nettype none

module memoryStage #(
    parameter int xlen = 32,
    parameter int dmemAddrBits = 6
)(
    input  logic clk,
    input  logic rstN,
    input  logic regWriteM,
    input  logic [1:0] resultSrcM,
    input  logic memWriteM,
    input  logic [xlen-1:0] aluResultM,
    input  logic [xlen-1:0] writeDataM,
    input  logic [rvPkg::regAddrBits-1:0] rdM,
    input  logic [xlen-1:0] pcPlus4M,
    output logic regWriteW,
    output logic [rvPkg::regAddrBits-1:0] rdW,
    output logic [xlen-1:0] resultW
);

    logic [xlen-1:0] dmem [2**dmemAddrBits];
    logic [dmemAddrBits-1:0] wordAddrM;
    logic [xlen-1:0] readDataM, readDataW, aluResultW, pcPlus4W;
    logic [1:0] resultSrcW;

    // word access only
    assign wordAddrM = aluResultM[dmemAddrBits+1:2];
    assign readDataM = dmem[wordAddrM];

    always_ff @(posedge clk) begin
        if (memWriteM) begin
            dmem[wordAddrM] <= writeDataM;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteW  <= 1'b0;
            resultSrcW <= rvPkg::resAlu;
            rdW        <= '0;
        end else begin
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
            rdW        <= rdM;
        end
    end

    always_ff @(posedge clk) begin
        readDataW  <= readDataM;
        aluResultW <= aluResultM;
        pcPlus4W   <= pcPlus4M;
    end

    always_comb begin
        case (resultSrcW)
            rvPkg::resMem: resultW = readDataW;
            rvPkg::resPc4: resultW = pcPlus4W;
            default:       resultW = aluResultW;
        endcase
    end

endmodule

`default_nettype wire

//--- source/pipeCpu.sv
`timescale 1ns/1ns
`default_nettype none

module pipeCpu #(
    parameter int xlen = 32,
    parameter int imemAddrBits = 6,
    parameter int dmemAddrBits = 6
)(
    input  logic clk,
    input  logic rstN,
    input  logic run,
    input  logic loadEn,
    input  logic [imemAddrBits-1:0] loadAddr,
    input  logic [xlen-1:0] loadData,
    output logic [xlen-1:0] a0
);

    // fetch to decode
    logic [xlen-1:0] instrD, pcD, pcPlus4D;

    // decode to execute
    logic regWriteE, memWriteE, branchE, branchNeE, jumpE, aluSrcE;
    logic [1:0] resultSrcE;
    logic [2:0] aluOpE;
    logic [xlen-1:0] rd1E, rd2E, pcE, immE, pcPlus4E;
    logic [rvPkg::regAddrBits-1:0] rs1D, rs2D, rs1E, rs2E, rdE;

    // execute to memory
    logic pcSrcE;
    logic [xlen-1:0] pcTargetE;
    logic regWriteM, memWriteM;
    logic [1:0] resultSrcM;
    logic [xlen-1:0] aluResultM, writeDataM, pcPlus4M;
    logic [rvPkg::regAddrBits-1:0] rdM;

    // writeback, fed back to decode and execute
    logic regWriteW;
    logic [rvPkg::regAddrBits-1:0] rdW;
    logic [xlen-1:0] resultW;

    // hazard controls
    logic stallF, stallD, flushD, flushE;
    logic [1:0] forwardAE, forwardBE;

    fetchStage #(.xlen(xlen), .imemAddrBits(imemAddrBits)) fetchStage_i (
        .clk(clk), .rstN(rstN), .run(run),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .stallF(stallF), .stallD(stallD), .flushD(flushD),
        .pcSrcE(pcSrcE), .pcTargetE(pcTargetE),
        .instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D)
    );

    decodeStage #(.xlen(xlen)) decodeStage_i (
        .clk(clk), .rstN(rstN), .flushE(flushE),
        .instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D),
        .regWriteW(regWriteW), .rdW(rdW), .resultW(resultW),
        .regWriteE(regWriteE), .resultSrcE(resultSrcE), .memWriteE(memWriteE),
        .branchE(branchE), .branchNeE(branchNeE), .jumpE(jumpE),
        .aluOpE(aluOpE), .aluSrcE(aluSrcE),
        .rd1E(rd1E), .rd2E(rd2E), .pcE(pcE), .immE(immE), .pcPlus4E(pcPlus4E),
        .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE),
        .rs1D(rs1D), .rs2D(rs2D), .a0(a0)
    );

    executeStage #(.xlen(xlen)) executeStage_i (
        .clk(clk), .rstN(rstN),
        .regWriteE(regWriteE), .resultSrcE(resultSrcE), .memWriteE(memWriteE),
        .branchE(branchE), .branchNeE(branchNeE), .jumpE(jumpE),
        .aluOpE(aluOpE), .aluSrcE(aluSrcE),
        .rd1E(rd1E), .rd2E(rd2E), .pcE(pcE), .immE(immE), .pcPlus4E(pcPlus4E),
        .rdE(rdE),
        .forwardAE(forwardAE), .forwardBE(forwardBE),
        .aluResultM(aluResultM), .resultW(resultW),
        .pcSrcE(pcSrcE), .pcTargetE(pcTargetE),
        .regWriteM(regWriteM), .resultSrcM(resultSrcM), .memWriteM(memWriteM),
        .writeDataM(writeDataM), .rdM(rdM), .pcPlus4M(pcPlus4M)
    );

    memoryStage #(.xlen(xlen), .dmemAddrBits(dmemAddrBits)) memoryStage_i (
        .clk(clk), .rstN(rstN),
        .regWriteM(regWriteM), .resultSrcM(resultSrcM), .memWriteM(memWriteM),
        .aluResultM(aluResultM), .writeDataM(writeDataM), .rdM(rdM),
        .pcPlus4M(pcPlus4M),
        .regWriteW(regWriteW), .rdW(rdW), .resultW(resultW)
    );

    hazardUnit hazardUnit_i (
        .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE),
        .resultSrcE(resultSrcE), .pcSrcE(pcSrcE),
        .rdM(rdM), .regWriteM(regWriteM), .rdW(rdW), .regWriteW(regWriteW),
        .forwardAE(forwardAE), .forwardBE(forwardBE),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
    );

endmodule

`default_nettype wire

//--- source/rvPkg.sv
`default_nettype none

package rvPkg;

    // register index width
    localparam int regAddrBits = 5;

    // opcodes of the supported subset
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opLui    = 7'b0110111;

    // alu operations
    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluSub = 3'd1;
    localparam logic [2:0] aluAnd = 3'd2;
    localparam logic [2:0] aluOr  = 3'd3;
    localparam logic [2:0] aluSlt = 3'd4;

    // writeback result source
    localparam logic [1:0] resAlu = 2'd0;
    localparam logic [1:0] resMem = 2'd1;
    localparam logic [1:0] resPc4 = 2'd2;

    // operand forward select
    localparam logic [1:0] fwdReg = 2'd0;
    localparam logic [1:0] fwdWb  = 2'd1;
    localparam logic [1:0] fwdMem = 2'd2;

endpackage

`default_nettype wire

//--- tb/pipeCpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module pipeCpuTb;

    localparam int xlen = 32;
    localparam int imemAddrBits = 6;
    localparam int dataWords = 128;
    localparam int maxProgs = 8;
    localparam logic [31:0] endOfProgram = 32'hFFFF_FFFF;
    localparam int resetCycles = 16;
    localparam int holdCycles = 20;
    localparam int runTimeout = 200;
    // branch program, a0 changes early in its run
    localparam int resetProg = 2;

    logic clk;
    logic rstN;
    logic run;
    logic loadEn;
    logic [imemAddrBits-1:0] loadAddr;
    logic [xlen-1:0] loadData;
    logic [xlen-1:0] a0;

    logic [31:0] testData [dataWords];
    int progStart [maxProgs];
    int progLen [maxProgs];
    logic [31:0] progExpect [maxProgs];
    int numProgs;

    pipeCpu #(.xlen(xlen), .imemAddrBits(imemAddrBits), .dmemAddrBits(6)) pipeCpu_i (
        .clk(clk), .rstN(rstN), .run(run), .loadEn(loadEn),
        .loadAddr(loadAddr), .loadData(loadData), .a0(a0)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // record is words, terminator, expected a0; an empty record ends the list
    task automatic indexPrograms();
        int idx;
        int len;
        idx = 0;
        numProgs = 0;
        while (idx < dataWords && testData[idx] != endOfProgram) begin
            len = 0;
            while (idx + len < dataWords && testData[idx + len] != endOfProgram) begin
                len++;
            end
            if (idx + len + 1 >= dataWords || numProgs >= maxProgs
                    || len > 2**imemAddrBits) begin
                stopOnError("test data file is malformed or holds too much");
            end
            progStart[numProgs] = idx;
            progLen[numProgs] = len;
            progExpect[numProgs] = testData[idx + len + 1];
            numProgs++;
            idx = idx + len + 2;
        end
        if (numProgs <= resetProg) begin
            stopOnError("test data file holds too few programs");
        end
    endtask

    task automatic resetCpu();
        @(negedge clk);
        rstN = 1'b0;
        run = 1'b0;
        loadEn = 1'b0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        // register file cleared by reset
        assert (a0 == '0) else begin
            stopOnError($sformatf("ERR time=%0t signal=a0 expected=%h actual=%h",
                                  $time, 32'h0, a0));
        end
    endtask

    task automatic loadProgram(input int p);
        for (int i = 0; i < progLen[p]; i++) begin
            loadEn = 1'b1;
            loadAddr = imemAddrBits'(i);
            loadData = testData[progStart[p] + i];
            @(negedge clk);
        end
        loadEn = 1'b0;
    endtask

    task automatic waitForA0(input logic [31:0] expected);
        int cycles;
        cycles = 0;
        while (a0 !== expected) begin
            if (cycles >= runTimeout) begin
                stopOnError($sformatf("timeout, a0 never reached %h within %0d cycles",
                                      expected, runTimeout));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic runProgram(input int p);
        resetCpu();
        loadProgram(p);
        run = 1'b1;
        waitForA0(progExpect[p]);
        // program parks in a jal-to-self loop
        repeat (holdCycles) begin
            @(negedge clk);
            assert (a0 == progExpect[p]) else begin
                stopOnError($sformatf("ERR time=%0t signal=a0 expected=%h actual=%h",
                                      $time, progExpect[p], a0));
            end
        end
    endtask

    // starts a program and leaves it running once a0 has moved
    task automatic startProgram(input int p);
        int cycles;
        resetCpu();
        loadProgram(p);
        run = 1'b1;
        cycles = 0;
        while (a0 == '0) begin
            if (cycles >= runTimeout) begin
                stopOnError("timeout, a0 never left zero before the reset in mid run");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        rstN = 1'b0;
        run = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        $readmemh("tb/testdata.mem", testData);
        indexPrograms();
        for (int p = 0; p < numProgs; p++) begin
            runProgram(p);
        end
        // reset in mid run, then reload and rerun
        startProgram(resetProg);
        runProgram(resetProg);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/pipeCpu_chk.sv
`timescale 1ns/1ns
`default_nettype none

module pipeCpuChk (
    input logic clk,
    input logic rstN,
    input logic stallD,
    input logic flushD,
    input logic [1:0] forwardAE,
    input logic [1:0] forwardBE,
    input logic [rvPkg::regAddrBits-1:0] rdM,
    input logic [rvPkg::regAddrBits-1:0] rdW,
    input logic memWriteM,
    input logic regWriteW
);

    // load in execute and a redirect in execute exclude each other
    noStallWithFlush: assert property (@(posedge clk) disable iff (!rstN)
        !(stallD && flushD))
        else $error("decode register stalled and flushed in the same cycle");

    // pipeline registers come out of reset as bubbles
    quietAfterReset: assert property (@(posedge clk) !rstN |=> !memWriteM && !regWriteW)
        else $error("memory or register write active right after reset");

    noForwardFromX0A: assert property (@(posedge clk) disable iff (!rstN)
        (forwardAE != rvPkg::fwdMem || rdM != '0) && (forwardAE != rvPkg::fwdWb || rdW != '0))
        else $error("operand A forwarded from a write to x0");

    noForwardFromX0B: assert property (@(posedge clk) disable iff (!rstN)
        (forwardBE != rvPkg::fwdMem || rdM != '0) && (forwardBE != rvPkg::fwdWb || rdW != '0))
        else $error("operand B forwarded from a write to x0");

endmodule

// top level holds both the hazard unit and the memory stage signals
bind pipeCpu pipeCpuChk pipeCpuChk_i (
    .clk(clk), .rstN(rstN), .stallD(stallD), .flushD(flushD),
    .forwardAE(forwardAE), .forwardBE(forwardBE), .rdM(rdM), .rdW(rdW),
    .memWriteM(memWriteM), .regWriteW(regWriteW)
);

`default_nettype wire

//--- tb/testdata.mem
// one hex word per line: program words, FFFFFFFF, expected a0
// a lone FFFFFFFF after the last record ends the list
123450B7 // lui  x1, 0x12345
67808113 // addi x2, x1, 0x678
0FF00193 // addi x3, x0, 0xff
00317233 // and  x4, x2, x3
001262B3 // or   x5, x4, x1
40228333 // sub  x6, x5, x2
000323B3 // slt  x7, x6, x0
00730533 // add  x10, x6, x7
0000006F // jal  x0, 0
FFFFFFFF
FFFFFA01
12300093 // addi x1, x0, 0x123
00800113 // addi x2, x0, 8
00112223 // sw   x1, 4(x2)
00412183 // lw   x3, 4(x2)
00218533 // add  x10, x3, x2
0000006F // jal  x0, 0
FFFFFFFF
0000012B
00500513 // addi x10, x0, 5
00500093 // addi x1, x0, 5
00150663 // beq  x10, x1, +12 taken
10050513 // addi x10, x10, 0x100 flushed
20050513 // addi x10, x10, 0x200 flushed
00151463 // bne  x10, x1, +8 not taken
00350513 // addi x10, x10, 3
00151663 // bne  x10, x1, +12 taken
10050513 // addi x10, x10, 0x100 flushed
20050513 // addi x10, x10, 0x200 flushed
00150463 // beq  x10, x1, +8 not taken
00150513 // addi x10, x10, 1
0000006F // jal  x0, 0
FFFFFFFF
00000009
05500013 // addi x0, x0, 0x55
00C000EF // jal  x1, +12
7FF00513 // addi x10, x0, 0x7ff flushed
7FF00513 // addi x10, x0, 0x7ff skipped
00008533 // add  x10, x1, x0
02050513 // addi x10, x10, 0x20
0000006F // jal  x0, 0
FFFFFFFF
00000028
FFFFFFFF
